//--- hdl/icache_pkg.sv
// ======================================================================
// Instruction cache definitions
// Cache geometry and the packed types shared by the cache blocks
// ======================================================================
package icache_pkg;

  // ======================================================================
  // Geometry
  // ======================================================================

  // Address and word width
  localparam int XLEN          = 32;
  localparam int NUM_WAY       = 4;
  localparam int NUM_SET       = 16;
  // One line is 16 bytes
  localparam int BLK_BITS      = 128;
  localparam int WORDS_PER_BLK = BLK_BITS / XLEN;
  localparam int IDX_W         = $clog2(NUM_SET);
  localparam int BOFF_W        = $clog2(BLK_BITS / 8);
  localparam int TAG_W         = XLEN - IDX_W - BOFF_W;

  // ======================================================================
  // Processor side
  // ======================================================================

  // Word read request
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
  } cpu_req_t;

  // Read response, held for a single cycle
  typedef struct packed {
    logic            valid;
    logic            miss;
    logic [XLEN-1:0] data;
  } cpu_rsp_t;

  // ======================================================================
  // APB requester, read only
  // ======================================================================
  typedef struct packed {
    logic            psel;
    logic            penable;
    logic [XLEN-1:0] paddr;
  } apb_req_t;

  typedef struct packed {
    logic            pready;
    logic [XLEN-1:0] prdata;
  } apb_rsp_t;

  // ======================================================================
  // Array entries
  // ======================================================================

  // Tag array entry with its valid bit on top
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  // A line as words, word 0 in the low bits
  typedef logic [WORDS_PER_BLK-1:0][XLEN-1:0] blk_t;

  // One bit per way
  typedef logic [NUM_WAY-1:0] way_vec_t;

  // Tree bits of one set, bit 0 is the root
  typedef logic [NUM_WAY-2:0] plru_node_t;

endpackage

//--- hdl/way_ram.sv
// ======================================================================
// Way RAM
// Single-port synchronous array of one cache way, one entry per set
// ======================================================================
module way_ram
  import icache_pkg::*;
#(
  parameter type entry_t = logic
) (
  input  logic             clk_i,
  input  logic [IDX_W-1:0] idx_i,
  input  logic             we_i,
  input  entry_t           wdata_i,
  output entry_t           rdata_o
);

  // Storage, one entry per set
  entry_t mem [NUM_SET];

  // Registered read, a write shows up on the read port at once
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[idx_i] <= wdata_i;
      rdata_o    <= wdata_i;
    end else begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

//--- hdl/plru_tree.sv
// ======================================================================
// Tree pseudo-LRU
// Per-set tree bits in registers, with update on touch and victim pick
// ======================================================================
module plru_tree
  import icache_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [IDX_W-1:0] idx_i,
  input  logic             touch_i,
  input  way_vec_t         touch_way_i,
  input  logic             clear_i,
  output way_vec_t         victim_o
);

  // Tree layout for four ways
  //   bit 0 : root, 0 points at ways 0/1, 1 points at ways 2/3
  //   bit 1 : left pair, 0 points at way 0, 1 at way 1
  //   bit 2 : right pair, 0 points at way 2, 1 at way 3

  plru_node_t node_q [NUM_SET];
  plru_node_t node_cur;
  plru_node_t node_upd;

  // Registers give the set state in the same cycle as the index
  assign node_cur = node_q[idx_i];

  // ======================================================================
  // Update on touch
  // ======================================================================

  // Every node on the path of the touched way turns to the other side
  always_comb begin
    node_upd = node_cur;
    if (touch_way_i[0] || touch_way_i[1]) begin
      node_upd[0] = 1'b1;
      // Way 0 touched so point at way 1, and the other way round
      node_upd[1] = touch_way_i[0];
    end else if (touch_way_i[2] || touch_way_i[3]) begin
      node_upd[0] = 1'b0;
      node_upd[2] = touch_way_i[2];
    end
  end

  // ======================================================================
  // Victim walk from the root
  // ======================================================================
  always_comb begin
    if (!node_cur[0]) begin
      victim_o = node_cur[1] ? way_vec_t'(2) : way_vec_t'(1);
    end else begin
      victim_o = node_cur[2] ? way_vec_t'(8) : way_vec_t'(4);
    end
  end

  // Clear wins over touch, the flush walk never touches
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        node_q[s] <= '0;
      end
    end else if (clear_i) begin
      node_q[idx_i] <= '0;
    end else if (touch_i) begin
      node_q[idx_i] <= node_upd;
    end
  end

endmodule

//--- hdl/line_fill.sv
// ======================================================================
// Line fill
// APB requester that reads one cache line as four word transfers
// and collects the words in a line buffer
// ======================================================================
module line_fill
  import icache_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  logic [XLEN-1:0] line_addr_i,
  output apb_req_t        apb_o,
  input  apb_rsp_t        apb_i,
  output logic            done_o,
  output blk_t            line_o
);

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_SETUP,
    FS_ACCESS
  } fill_state_e;

  fill_state_e                        state_q;
  // Word being fetched, wraps to zero after the last one
  logic [$clog2(WORDS_PER_BLK)-1:0]   word_q;
  logic [XLEN-1:0]                    addr_q;
  blk_t                               line_q;
  logic                               last_word;
  logic                               beat_done;

  assign last_word = word_q == WORDS_PER_BLK - 1;
  // Access phase ends on pready
  assign beat_done = (state_q == FS_ACCESS) && apb_i.pready;
  assign done_o    = beat_done && last_word;

  // ======================================================================
  // APB phases
  // ======================================================================

  // Idle doubles as the gap between transfers, so psel drops each time
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= FS_IDLE;
      word_q  <= '0;
    end else begin
      unique case (state_q)
        FS_IDLE: begin
          // A nonzero count means a fill is still running
          if (start_i || word_q != '0) begin
            state_q <= FS_SETUP;
          end
        end
        FS_SETUP: begin
          state_q <= FS_ACCESS;
        end
        FS_ACCESS: begin
          if (apb_i.pready) begin
            state_q <= FS_IDLE;
            word_q  <= word_q + 1'b1;
          end
        end
        default: begin
          state_q <= FS_IDLE;
        end
      endcase
    end
  end

  // Line base address and buffer
  always_ff @(posedge clk_i) begin
    if (state_q == FS_IDLE && start_i && word_q == '0) begin
      addr_q <= line_addr_i;
    end
    if (beat_done) begin
      line_q[word_q] <= apb_i.prdata;
    end
  end

  // Word address inside the line
  assign apb_o.psel    = state_q != FS_IDLE;
  assign apb_o.penable = state_q == FS_ACCESS;
  assign apb_o.paddr   = addr_q + XLEN'({word_q, 2'b00});

  // The last word goes straight out with the rest of the line
  always_comb begin
    line_o = line_q;
    if (done_o) begin
      line_o[WORDS_PER_BLK-1] = apb_i.prdata;
    end
  end

endmodule

//--- hdl/lookup_ctrl.sv
// ======================================================================
// Lookup control
// Request register, tag compare and hit/miss response, refill
// sequencing and the flush walk over all sets
// ======================================================================
module lookup_ctrl
  import icache_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  cpu_req_t                 cpu_req_i,
  output logic                     ready_o,
  output cpu_rsp_t                 cpu_rsp_o,
  output logic       [IDX_W-1:0]   ram_idx_o,
  output way_vec_t                 tag_we_o,
  output way_vec_t                 data_we_o,
  output tag_entry_t               tag_wdata_o,
  input  tag_entry_t [NUM_WAY-1:0] tag_rdata_i,
  input  blk_t       [NUM_WAY-1:0] data_rdata_i,
  input  way_vec_t                 victim_i,
  output logic                     plru_touch_o,
  output way_vec_t                 plru_way_o,
  output logic                     plru_clear_o,
  output logic                     fill_start_o,
  output logic       [XLEN-1:0]    fill_addr_o,
  input  logic                     fill_done_i,
  input  blk_t                     fill_line_i
);

  typedef enum logic [1:0] {
    ST_FLUSH,
    ST_RUN,
    ST_FILL
  } state_e;

  state_e           state_q;
  state_e           state_d;
  cpu_req_t         req_q;
  logic [IDX_W-1:0] flush_idx_q;
  // Flush seen during a refill, served when the refill ends
  logic             flush_pend_q;
  logic [IDX_W-1:0] req_idx;
  logic [TAG_W-1:0] req_tag;
  logic [1:0]       word_sel;
  way_vec_t         hit_vec;
  logic             hit;
  blk_t             hit_line;
  logic             lookup_miss;
  logic             fill_end;
  logic             flush_last;

  // Fields of the request in lookup
  assign req_idx  = req_q.addr[BOFF_W +: IDX_W];
  assign req_tag  = req_q.addr[XLEN-1 -: TAG_W];
  assign word_sel = req_q.addr[BOFF_W-1:2];

  // ======================================================================
  // Tag compare
  // ======================================================================
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == req_tag);
      // At most one way matches
      if (hit_vec[w]) begin
        hit_line = hit_line | data_rdata_i[w];
      end
    end
  end

  assign hit         = |hit_vec;
  assign lookup_miss = (state_q == ST_RUN) && req_q.valid && !hit;
  assign fill_end    = (state_q == ST_FILL) && fill_done_i;
  assign flush_last  = flush_idx_q == IDX_W'(NUM_SET - 1);

  // Open for a new request unless a miss or a flush takes over
  assign ready_o = (state_q == ST_RUN) && !lookup_miss && !flush_i;

  // ======================================================================
  // Control FSM
  // ======================================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_FLUSH: begin
        if (flush_last) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (lookup_miss) begin
          state_d = ST_FILL;
        end else if (flush_i) begin
          state_d = ST_FLUSH;
        end
      end
      ST_FILL: begin
        if (fill_done_i) begin
          state_d = (flush_pend_q || flush_i) ? ST_FLUSH : ST_RUN;
        end
      end
      default: begin
        state_d = ST_FLUSH;
      end
    endcase
  end

  // Reset starts with the flush walk at set 0
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= ST_FLUSH;
      flush_idx_q  <= '0;
      flush_pend_q <= 1'b0;
      req_q.valid  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_FLUSH) begin
        flush_idx_q <= flush_last ? '0 : flush_idx_q + 1'b1;
      end
      if (state_d == ST_FLUSH) begin
        flush_pend_q <= 1'b0;
      end else if (flush_i && state_d == ST_FILL) begin
        flush_pend_q <= 1'b1;
      end
      // Missed request stays put until its line is in
      if (ready_o) begin
        req_q <= cpu_req_i;
      end else if (state_d != ST_FILL) begin
        req_q.valid <= 1'b0;
      end
    end
  end

  // ======================================================================
  // Array and PLRU control
  // ======================================================================

  // Incoming address by default so a hit can be followed at once
  always_comb begin
    if (state_q == ST_FLUSH) begin
      ram_idx_o = flush_idx_q;
    end else if (state_q == ST_FILL || lookup_miss) begin
      ram_idx_o = req_idx;
    end else begin
      ram_idx_o = cpu_req_i.addr[BOFF_W +: IDX_W];
    end
  end

  // Flush writes invalid tags to all ways, refill writes the victim
  assign tag_we_o    = (state_q == ST_FLUSH) ? '1 : (fill_end ? victim_i : '0);
  assign data_we_o   = fill_end ? victim_i : '0;
  assign tag_wdata_o = (state_q == ST_FLUSH) ? '0 : {1'b1, req_tag};

  // Replacement order follows the refills
  assign plru_touch_o = fill_end;
  assign plru_way_o   = victim_i;
  assign plru_clear_o = state_q == ST_FLUSH;

  // One start pulse per miss, line aligned
  assign fill_start_o = lookup_miss;
  assign fill_addr_o  = {req_q.addr[XLEN-1:BOFF_W], {BOFF_W{1'b0}}};

  // ======================================================================
  // Response
  // ======================================================================
  always_comb begin
    cpu_rsp_o.valid = ((state_q == ST_RUN) && req_q.valid && hit) || fill_end;
    cpu_rsp_o.miss  = state_q == ST_FILL;
    // Missed word comes from the line buffer
    if (state_q == ST_FILL) begin
      cpu_rsp_o.data = fill_line_i[word_sel];
    end else begin
      cpu_rsp_o.data = hit_line[word_sel];
    end
  end

endmodule

//--- hdl/icache_top.sv
// ======================================================================
// Instruction cache top
// 4-way set-associative cache with tree PLRU and APB line refill
// ======================================================================
module icache_top
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  cpu_req_t cpu_req_i,
  output logic     ready_o,
  output cpu_rsp_t cpu_rsp_o,
  output apb_req_t apb_o,
  input  apb_rsp_t apb_i
);

  // Array port, shared index for tags, data and PLRU
  logic       [IDX_W-1:0]   ram_idx;
  way_vec_t                 tag_we;
  way_vec_t                 data_we;
  tag_entry_t               tag_wdata;
  tag_entry_t [NUM_WAY-1:0] tag_rdata;
  blk_t       [NUM_WAY-1:0] data_rdata;

  // Replacement
  way_vec_t                 victim;
  logic                     plru_touch;
  way_vec_t                 plru_way;
  logic                     plru_clear;

  // Refill
  logic                     fill_start;
  logic       [XLEN-1:0]    fill_addr;
  logic                     fill_done;
  blk_t                     fill_line;

  lookup_ctrl u_lookup_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .cpu_req_i    (cpu_req_i),
    .ready_o      (ready_o),
    .cpu_rsp_o    (cpu_rsp_o),
    .ram_idx_o    (ram_idx),
    .tag_we_o     (tag_we),
    .data_we_o    (data_we),
    .tag_wdata_o  (tag_wdata),
    .tag_rdata_i  (tag_rdata),
    .data_rdata_i (data_rdata),
    .victim_i     (victim),
    .plru_touch_o (plru_touch),
    .plru_way_o   (plru_way),
    .plru_clear_o (plru_clear),
    .fill_start_o (fill_start),
    .fill_addr_o  (fill_addr),
    .fill_done_i  (fill_done),
    .fill_line_i  (fill_line)
  );

  plru_tree u_plru_tree (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .idx_i       (ram_idx),
    .touch_i     (plru_touch),
    .touch_way_i (plru_way),
    .clear_i     (plru_clear),
    .victim_o    (victim)
  );

  line_fill u_line_fill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (fill_start),
    .line_addr_i (fill_addr),
    .apb_o       (apb_o),
    .apb_i       (apb_i),
    .done_o      (fill_done),
    .line_o      (fill_line)
  );

  // ======================================================================
  // Tag and data arrays, one pair per way
  // ======================================================================
  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    way_ram #(
      .entry_t (tag_entry_t)
    ) u_tag_ram (
      .clk_i   (clk_i),
      .idx_i   (ram_idx),
      .we_i    (tag_we[w]),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    // Data is only ever written from the line buffer
    way_ram #(
      .entry_t (blk_t)
    ) u_data_ram (
      .clk_i   (clk_i),
      .idx_i   (ram_idx),
      .we_i    (data_we[w]),
      .wdata_i (fill_line),
      .rdata_o (data_rdata[w])
    );
  end

endmodule

//--- bench/tb_clock.sv
// ======================================================================
// Testbench clock and reset
// Free running clock and an active low reset held for a few cycles
// ======================================================================
module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3,
  parameter int SKEW_NS      = 10
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands just after an edge, like the other inputs
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #SKEW_NS;
    rst_no = 1'b1;
  end

endmodule

//--- bench/icache_tb.sv
// ======================================================================
// Instruction cache testbench
// Directed tests against an APB memory model with random wait states
// ======================================================================
module icache_tb
  import icache_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ns;

  // Inputs change this long after the rising edge
  localparam int DRIVE_SKEW = 10;
  // Memory returns the word address mixed with this key
  localparam logic [31:0] MEM_KEY = 32'h5A5A_C3C3;
  // About 50 requests at a worst miss of 28 cycles, two walks of 16, with margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic     clk;
  logic     rst_n;
  logic     flush;
  logic     ready;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  // Memory model state
  logic [7:0]  lfsr;
  logic [1:0]  wait_left;
  logic [31:0] setup_addr;
  logic        prev_sel;
  int          xfer_cnt;
  int          cycles;

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  icache_top dut0 (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .flush_i   (flush),
    .cpu_req_i (cpu_req),
    .ready_o   (ready),
    .cpu_rsp_o (cpu_rsp),
    .apb_o     (apb_req),
    .apb_i     (apb_rsp)
  );

  // ======================================================================
  // Helpers
  // ======================================================================

  // Memory content rule
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ MEM_KEY;
  endfunction

  // Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s: %s expected %h, actual %h", name, what, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "Check failed");
    end
  endtask

  // Counts the sample points with ready_o still low
  task automatic wait_ready(output int busy);
    busy = 0;
    @(negedge clk);
    while (!ready) begin
      busy++;
      @(negedge clk);
    end
  endtask

  // One read, checked for miss flag, data, latency and APB traffic
  task automatic read_word(input string name, input logic [31:0] addr,
                           input logic exp_miss);
    int xfer_start;
    int lat;
    xfer_start = xfer_cnt;
    lat = 0;
    @(posedge clk);
    #DRIVE_SKEW;
    cpu_req.valid = 1'b1;
    cpu_req.addr  = addr;
    // Taken at the edge after ready_o is seen high
    do begin
      @(negedge clk);
    end while (!ready);
    @(posedge clk);
    #DRIVE_SKEW;
    cpu_req.valid = 1'b0;
    do begin
      @(negedge clk);
      lat++;
      if (exp_miss) begin
        check_value(name, "ready during refill", 32'd0, {31'd0, ready});
      end
    end while (!cpu_rsp.valid);
    if (!exp_miss) begin
      check_value(name, "hit latency", 32'd1, 32'(lat));
    end
    check_value(name, "miss flag", {31'd0, exp_miss}, {31'd0, cpu_rsp.miss});
    check_value(name, "read data", mem_word(addr), cpu_rsp.data);
    check_value(name, "APB transfers", exp_miss ? 32'd4 : 32'd0, 32'(xfer_cnt - xfer_start));
    // A response lasts one cycle
    @(negedge clk);
    check_value(name, "rsp valid after response", 32'd0, {31'd0, cpu_rsp.valid});
    if (exp_miss) begin
      // Open again one cycle after the miss response
      check_value(name, "ready after refill", 32'd1, {31'd0, ready});
    end
  endtask

  // ======================================================================
  // APB memory model
  // ======================================================================
  always begin
    @(posedge clk);
    #DRIVE_SKEW;
    apb_rsp.pready = 1'b0;
    if (apb_req.psel && !apb_req.penable) begin
      check_value("apb_model", "psel gap before setup", 32'd0, {31'd0, prev_sel});
      // Two fresh bits pick zero to three wait states
      lfsr = lfsr_step(lfsr);
      wait_left[0] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      wait_left[1] = lfsr[0];
      setup_addr = apb_req.paddr;
    end else if (apb_req.psel && apb_req.penable) begin
      check_value("apb_model", "paddr in access", setup_addr, apb_req.paddr);
      if (wait_left == 2'd0) begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = mem_word(apb_req.paddr);
        xfer_cnt++;
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
    prev_sel = apb_req.psel;
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  // ======================================================================
  // Tests
  // ======================================================================

  // Walk after reset, then a cold miss at 0x100
  task automatic reset_and_cold_miss();
    int busy;
    @(negedge clk);
    check_value("reset", "ready", 32'd0, {31'd0, ready});
    check_value("reset", "rsp valid", 32'd0, {31'd0, cpu_rsp.valid});
    check_value("reset", "psel", 32'd0, {31'd0, apb_req.psel});
    check_value("reset", "penable", 32'd0, {31'd0, apb_req.penable});
    wait_ready(busy);
    check_value("reset", "flush walk cycles", 32'(NUM_SET), 32'(busy + 1));
    read_word("cold_miss", 32'h0000_0100, 1'b1);
  endtask

  // Back-to-back reads over the whole line, one response per cycle
  task automatic line_hits();
    int          xfer_start;
    logic [31:0] base;
    xfer_start = xfer_cnt;
    base = 32'h0000_0100;
    @(posedge clk);
    #DRIVE_SKEW;
    cpu_req.valid = 1'b1;
    cpu_req.addr  = base;
    @(negedge clk);
    check_value("line_hits", "ready", 32'd1, {31'd0, ready});
    for (int i = 0; i < WORDS_PER_BLK; i++) begin
      @(posedge clk);
      #DRIVE_SKEW;
      if (i < WORDS_PER_BLK - 1) begin
        cpu_req.addr = base + 32'(4 * (i + 1));
      end else begin
        cpu_req.valid = 1'b0;
      end
      @(negedge clk);
      check_value("line_hits", "rsp valid", 32'd1, {31'd0, cpu_rsp.valid});
      check_value("line_hits", "miss flag", 32'd0, {31'd0, cpu_rsp.miss});
      check_value("line_hits", "read data", mem_word(base + 32'(4 * i)), cpu_rsp.data);
      if (i < WORDS_PER_BLK - 1) begin
        check_value("line_hits", "ready", 32'd1, {31'd0, ready});
      end
    end
    check_value("line_hits", "APB transfers", 32'd0, 32'(xfer_cnt - xfer_start));
  endtask

  // Five lines into set 5, the fifth fill evicts way 0
  task automatic set_replacement();
    logic [31:0] lines [5];
    for (int i = 0; i < 5; i++) begin
      lines[i] = 32'h0000_0054 + 32'h0000_1000 * 32'(i + 1);
      read_word("replacement_fill", lines[i], 1'b1);
    end
    read_word("replacement_fifth", lines[4], 1'b0);
    read_word("replacement_fourth", lines[3], 1'b0);
    read_word("replacement_first", lines[0], 1'b1);
  endtask

  // A line that hits misses again after a flush
  task automatic flush_invalidate();
    int busy;
    read_word("flush_before", 32'h0000_0104, 1'b0);
    @(posedge clk);
    #DRIVE_SKEW;
    flush = 1'b1;
    @(negedge clk);
    check_value("flush", "ready during flush", 32'd0, {31'd0, ready});
    @(posedge clk);
    #DRIVE_SKEW;
    flush = 1'b0;
    wait_ready(busy);
    check_value("flush", "flush walk cycles", 32'(NUM_SET), 32'(busy));
    read_word("flush_after", 32'h0000_0104, 1'b1);
  endtask

  // One miss per set under wait states, then the same lines as hits
  task automatic wait_state_sweep();
    logic [31:0] addr;
    for (int s = 0; s < NUM_SET; s++) begin
      addr = 32'h0002_0000 + 32'(s * 16 + (s % 4) * 4);
      read_word("sweep_miss", addr, 1'b1);
    end
    for (int s = 0; s < NUM_SET; s++) begin
      addr = 32'h0002_0000 + 32'(s * 16 + (s % 4) * 4);
      read_word("sweep_hit", addr, 1'b0);
    end
  endtask

  // ======================================================================
  // Sequence
  // ======================================================================
  initial begin
    cpu_req  = '0;
    flush    = 1'b0;
    apb_rsp  = '0;
    lfsr     = 8'd86;
    prev_sel = 1'b0;
    xfer_cnt = 0;
    cycles   = 0;
    wait (rst_n === 1'b1);
    reset_and_cold_miss();
    line_hits();
    set_replacement();
    flush_invalidate();
    wait_state_sweep();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- sources.f
hdl/icache_pkg.sv
hdl/way_ram.sv
hdl/plru_tree.sv
hdl/line_fill.sv
hdl/lookup_ctrl.sv
hdl/icache_top.sv
bench/tb_clock.sv
bench/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FLAGS     ?= --binary --assert --timescale 1ns/1ns -Wno-fatal

BUILD_DIR := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove the build directory $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) FLAGS='$(FLAGS)'"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f sources.f
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
